//--- Bender.yml
package:
  name: mem_sys

sources:
  - rtl/mem_sys_pkg.sv
  - rtl/bus_decode.sv
  - rtl/ram_1p.sv
  - rtl/timer_regs.sv
  - rtl/resp_mux.sv
  - rtl/mem_sys_top.sv
  - target: simulation
    files:
      - bench/tb_clk_gen.sv
      - bench/mem_sys_props.sv
      - bench/tb_mem_sys.sv

//--- bench/mem_sys_props.sv
/*
 * Protocol assertions for the memory system top, attached by bind.
 */
`timescale 1ns/1ns

module mem_sys_props (
  input logic                  clk_i,
  input logic                  rst_ni,
  input mem_sys_pkg::bus_req_t req_i,
  input mem_sys_pkg::bus_rsp_t rsp_i,
  input logic                  irq_i
);

  int fail_cnt = 0;  // failed assertions so far.

  // every strobe is answered on the next edge, and only strobes are.
  a_rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.req |=> rsp_i.valid)
    else begin
      $error("no response valid one cycle after a request");
      fail_cnt++;
    end

  a_no_extra_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !req_i.req |=> !rsp_i.valid)
    else begin
      $error("response valid without a request");
      fail_cnt++;
    end

  a_err_with_valid: assert property (@(posedge clk_i)
    rsp_i.err |-> rsp_i.valid)
    else begin
      $error("error flag set without response valid");
      fail_cnt++;
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (rsp_i == '0) && !irq_i)
    else begin
      $error("outputs not low during reset");
      fail_cnt++;
    end

endmodule

bind mem_sys_top mem_sys_props mem_sys_props_i (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .req_i  (host_req_i),
  .rsp_i  (host_rsp_o),
  .irq_i  (timer_irq_o)
);

//--- bench/mem_sys_stim.txt
# test wr addr be wdata exp_rdata exp_err exp_irq (hex for addr, be and data)
# a '-' marks an expected field that is not compared
1 1 00000000 f 11111111 - 0 0
1 1 000001fc f 22222222 - 0 0
1 1 00000040 f 33333333 - 0 0
1 0 00000000 0 00000000 11111111 0 0
1 0 000001fc 0 00000000 22222222 0 0
1 0 00000040 0 00000000 33333333 0 0
2 1 00000040 3 aabbccdd 33333333 0 0
2 1 00000040 8 44556677 3333ccdd 0 0
2 0 00000040 0 00000000 4433ccdd 0 0
3 1 00000080 f 5a5a5a5a - 0 0
3 0 00000080 0 00000000 5a5a5a5a 0 0
3 1 00000080 f a5a5a5a5 5a5a5a5a 0 0
3 0 00000080 0 00000000 a5a5a5a5 0 0
4 1 00000200 f deadbeef 00000000 1 0
4 0 00000200 0 00000000 00000000 1 0
4 1 20000000 f cafef00d 00000000 1 0
4 0 20000000 0 00000000 00000000 1 0
4 0 00000000 0 00000000 11111111 0 0
5 1 0001000c f 00000000 ffffffff 0 0
5 1 00010008 f 00000008 ffffffff 0 1
5 1 0001000c f ffffffff 00000000 0 0
5 0 00010000 0 00000000 - 0 -
5 0 00010008 0 00000000 00000008 0 0

//--- bench/tb_clk_gen.sv
/*
 * Testbench clock and reset source.
 */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period.
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_no <= 1'b1;  // released on a rising edge after 16 cycles.
  end

endmodule

//--- bench/tb_mem_sys.sv
/*
 * Testbench top: replays the stimulus file against the memory system
 * and checks each response and the timer interrupt.
 */
`timescale 1ns/1ns

module tb_mem_sys;

  typedef struct packed {
    logic               rd_care;
    mem_sys_pkg::data_t rdata;
    logic               err;
    logic               irq_care;
    logic               irq;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  mem_sys_pkg::bus_req_t host_req;
  mem_sys_pkg::bus_rsp_t host_rsp;
  logic                  timer_irq;

  expect_t pend_exp;  // expectation for the request in flight.
  logic    pend;
  logic    irq_due;   // interrupt level still to be checked.
  logic    irq_want;
  int      cur_test = -1;
  int      test_errs;
  int      errors;
  int      checks;

  tb_clk_gen tb_clk_gen_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mem_sys_top mem_sys_top_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .host_req_i  (host_req),
    .host_rsp_o  (host_rsp),
    .timer_irq_o (timer_irq)
  );

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_rdata(input mem_sys_pkg::data_t got, input mem_sys_pkg::data_t want);
    checks++;
    if (got !== want) begin
      $display("** Error test %0d: host_rsp_o.rdata got %h expected %h", cur_test, got, want);
      test_errs++;
    end
  endtask

  task automatic check_err(input logic got, input logic want);
    checks++;
    if (got !== want) begin
      $display("** Error test %0d: host_rsp_o.err got %h expected %h", cur_test, got, want);
      test_errs++;
    end
  endtask

  task automatic check_irq(input logic got, input logic want);
    checks++;
    if (got !== want) begin
      $display("** Error test %0d: timer_irq_o got %h expected %h", cur_test, got, want);
      test_errs++;
    end
  endtask

  //////////////////////////////
  // sequencing
  //////////////////////////////
  // The answer to the request driven on the previous falling edge is due now.
  // The interrupt is registered behind the compare, so its level for a request
  // shows one cycle after that request's response.
  task automatic collect_response();
    int waited;
    waited = 0;
    if (irq_due) begin
      check_irq(timer_irq, irq_want);
      irq_due = 1'b0;
    end
    while (pend && !host_rsp.valid && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (pend && !host_rsp.valid) begin
      $display("test %0d: no response valid within 4 cycles of the request", cur_test);
      test_errs++;
    end else if (pend) begin
      if (pend_exp.rd_care) check_rdata(host_rsp.rdata, pend_exp.rdata);
      check_err(host_rsp.err, pend_exp.err);
      irq_due  = pend_exp.irq_care;
      irq_want = pend_exp.irq;
    end
    pend = 1'b0;
  endtask

  // drains the last request of a test and its interrupt, then idles.
  task automatic close_test();
    @(negedge clk);
    collect_response();
    host_req = '0;
    @(negedge clk);
    collect_response();
    if (cur_test >= 0) begin
      $display("test %0d: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "mismatch",
               test_errs);
      errors += test_errs;
    end
    test_errs = 0;
  endtask

  task automatic run_stimulus(input int fd);
    string              line;
    string              rd_s;
    string              irq_s;
    int                 test;
    int                 wr;
    int                 err;
    int                 irq_v;
    mem_sys_pkg::addr_t addr;
    mem_sys_pkg::strb_t be;
    mem_sys_pkg::data_t wdata;
    mem_sys_pkg::data_t rdata_v;
    expect_t            want;
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#") continue;
      if ($sscanf(line, "%d %d %h %h %h %s %d %s", test, wr, addr, be, wdata, rd_s, err,
                  irq_s) != 8) continue;
      if (test != cur_test) begin
        close_test();
        cur_test = test;
      end
      rdata_v = '0;
      irq_v   = 0;
      if (rd_s != "-") void'($sscanf(rd_s, "%h", rdata_v));
      if (irq_s != "-") void'($sscanf(irq_s, "%d", irq_v));
      want = '{rd_care: (rd_s != "-"), rdata: rdata_v, err: err[0],
               irq_care: (irq_s != "-"), irq: irq_v[0]};
      @(negedge clk);
      collect_response();
      host_req = '{req: 1'b1, we: wr[0], be: be, addr: addr, wdata: wdata};
      pend_exp = want;
      pend     = 1'b1;
    end
    close_test();
  endtask

  task automatic wait_reset(output logic ok);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (rst_n !== 1'b1 && cycles < 40);
    ok = (rst_n === 1'b1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  initial begin : main_seq
    int   fd;
    int   asrt_fails;
    logic rst_ok;
    host_req  = '0;
    pend      = 1'b0;
    pend_exp  = '0;
    irq_due   = 1'b0;
    irq_want  = 1'b0;
    test_errs = 0;
    errors    = 0;
    checks    = 0;
    fd = $fopen("bench/mem_sys_stim.txt", "r");
    wait_reset(rst_ok);
    if (fd == 0) begin
      abort_run("cannot open bench/mem_sys_stim.txt for reading");
    end else if (!rst_ok) begin
      abort_run("reset was not released within 40 cycles");
    end else begin
      run_stimulus(fd);
      $fclose(fd);
      asrt_fails = mem_sys_top_i.mem_sys_props_i.fail_cnt;
      $display("closing counts: %0d checks, %0d errors, %0d assertion failures", checks,
               errors, asrt_fails);
      if (errors == 0 && asrt_fails == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
      $finish;
    end
  end

endmodule

//--- rtl/bus_decode.sv
/*
 * Host address decoder: picks RAM, timer or unmapped per request.
 */
`timescale 1ns/1ns

module bus_decode (
  input  mem_sys_pkg::bus_req_t host_req_i,
  output mem_sys_pkg::bus_req_t ram_req_o,
  output mem_sys_pkg::bus_req_t tmr_req_o,
  output mem_sys_pkg::dev_sel_t dev_sel_o
);

  mem_sys_pkg::addr_t ram_off;
  mem_sys_pkg::addr_t tmr_off;
  logic               ram_hit;
  logic               tmr_hit;

  // offset into each window, wraps below the base so one compare does.
  assign ram_off = host_req_i.addr - mem_sys_pkg::RamBase;
  assign tmr_off = host_req_i.addr - mem_sys_pkg::TmrBase;

  assign ram_hit = (ram_off < mem_sys_pkg::RamBytes);
  assign tmr_hit = (tmr_off < mem_sys_pkg::TmrBytes);

  //////////////////////////////
  // gated requests
  //////////////////////////////
  always_comb begin
    ram_req_o     = host_req_i;
    tmr_req_o     = host_req_i;
    ram_req_o.req = host_req_i.req & ram_hit;  // strobe only for a RAM hit.
    tmr_req_o.req = host_req_i.req & tmr_hit;
  end

  // Selection is sent on to the response side; none means an idle cycle.
  always_comb begin
    if (!host_req_i.req) begin
      dev_sel_o = mem_sys_pkg::DevNone;
    end else if (ram_hit) begin
      dev_sel_o = mem_sys_pkg::DevRam;
    end else if (tmr_hit) begin
      dev_sel_o = mem_sys_pkg::DevTmr;
    end else begin
      dev_sel_o = mem_sys_pkg::DevUnmapped;  // answered with an error.
    end
  end

endmodule

//--- rtl/mem_sys_pkg.sv
/*
 * Shared memory map, bus widths, request and response structs,
 * device-select encoding and the byte-lane merge helper.
 */
package mem_sys_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  typedef logic [31:0] addr_t;  // byte address.
  typedef logic [31:0] data_t;  // one bus word.
  typedef logic [3:0]  strb_t;  // one enable bit per byte lane.
  typedef logic [63:0] mtime_t; // timer counter and compare width.
  typedef logic [1:0]  dev_sel_t;

  //////////////////////////////
  // bus structs
  //////////////////////////////
  typedef struct packed {
    logic  req;   // single-cycle request strobe.
    logic  we;    // write enable.
    strb_t be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  valid; // one cycle per answered request.
    logic  err;   // set for an unmapped address.
    data_t rdata;
  } bus_rsp_t;

  // which device took a request
  localparam dev_sel_t DevNone     = 2'd0;
  localparam dev_sel_t DevRam      = 2'd1;
  localparam dev_sel_t DevTmr      = 2'd2;
  localparam dev_sel_t DevUnmapped = 2'd3;

  //////////////////////////////
  // memory map
  //////////////////////////////
  localparam addr_t RamBase   = 32'h0000_0000;
  localparam int    RamDepth  = 128;                    // words.
  localparam addr_t RamBytes  = addr_t'(RamDepth * 4);  // 512 bytes.
  localparam addr_t TmrBase   = 32'h0001_0000;
  localparam addr_t TmrBytes  = 32'd16;

  // timer word index, address bits 3 to 2
  localparam logic [1:0] TmrMtimeLo = 2'd0; // byte offset 0x0.
  localparam logic [1:0] TmrMtimeHi = 2'd1; // byte offset 0x4.
  localparam logic [1:0] TmrCmpLo   = 2'd2; // byte offset 0x8.
  localparam logic [1:0] TmrCmpHi   = 2'd3; // byte offset 0xC.

  localparam mtime_t TmrCmpReset = '1;      // no interrupt until written.

  // replaces the enabled byte lanes of a word.
  function automatic data_t apply_strb(data_t old_word, data_t new_word, strb_t be);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        merged[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

//--- rtl/mem_sys_top.sv
/*
 * Memory system top: decoder, RAM, timer and response multiplexer.
 */
`timescale 1ns/1ns

module mem_sys_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_sys_pkg::bus_req_t host_req_i,
  output mem_sys_pkg::bus_rsp_t host_rsp_o,
  output logic                  timer_irq_o
);

  mem_sys_pkg::bus_req_t ram_req;
  mem_sys_pkg::bus_req_t tmr_req;
  mem_sys_pkg::dev_sel_t dev_sel;
  mem_sys_pkg::data_t    ram_rdata;
  mem_sys_pkg::data_t    tmr_rdata;

  //////////////////////////////
  // request side
  //////////////////////////////
  bus_decode bus_decode_i (
    .host_req_i (host_req_i),
    .ram_req_o  (ram_req),
    .tmr_req_o  (tmr_req),
    .dev_sel_o  (dev_sel)
  );

  //////////////////////////////
  // devices
  //////////////////////////////
  ram_1p #(
    .Depth (mem_sys_pkg::RamDepth)
  ) ram_1p_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

  timer_regs timer_regs_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (tmr_req),
    .rdata_o (tmr_rdata),
    .irq_o   (timer_irq_o)
  );

  // response side
  resp_mux resp_mux_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dev_sel_i   (dev_sel),
    .ram_rdata_i (ram_rdata),
    .tmr_rdata_i (tmr_rdata),
    .rsp_o       (host_rsp_o)
  );

endmodule

//--- rtl/ram_1p.sv
/*
 * Single-port word RAM with byte-lane writes and one cycle read latency.
 */
`timescale 1ns/1ns

module ram_1p #(
  parameter int Depth = mem_sys_pkg::RamDepth
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_sys_pkg::bus_req_t req_i,
  output mem_sys_pkg::data_t    rdata_o
);

  localparam int Aw = $clog2(Depth);

  mem_sys_pkg::data_t mem [Depth];
  logic [Aw-1:0]      word_idx;

  // word index sits above the byte offset, higher bits are ignored.
  assign word_idx = req_i.addr[Aw+1:2];

  //////////////////////////////
  // write port
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      mem[word_idx] <= mem_sys_pkg::apply_strb(mem[word_idx], req_i.wdata, req_i.be);
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////
  // The old word is captured, so a write in the same request reads
  // back what was there before it.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req) begin
      rdata_o <= mem[word_idx];  // held until the next request.
    end
  end

endmodule

//--- rtl/resp_mux.sv
/*
 * Response side: delays the device selection and builds the host response.
 */
`timescale 1ns/1ns

module resp_mux (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_sys_pkg::dev_sel_t dev_sel_i,
  input  mem_sys_pkg::data_t    ram_rdata_i,
  input  mem_sys_pkg::data_t    tmr_rdata_i,
  output mem_sys_pkg::bus_rsp_t rsp_o
);

  mem_sys_pkg::dev_sel_t sel_q;

  // devices answer one cycle later, so the selection waits with them.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= mem_sys_pkg::DevNone;
    end else begin
      sel_q <= dev_sel_i;
    end
  end

  always_comb begin
    rsp_o.valid = (sel_q != mem_sys_pkg::DevNone);
    rsp_o.err   = (sel_q == mem_sys_pkg::DevUnmapped);
    case (sel_q)
      mem_sys_pkg::DevRam: rsp_o.rdata = ram_rdata_i;
      mem_sys_pkg::DevTmr: rsp_o.rdata = tmr_rdata_i;
      default:             rsp_o.rdata = '0;  // idle or unmapped.
    endcase
  end

endmodule

//--- rtl/timer_regs.sv
/*
 * Machine timer: free-running mtime, mtimecmp and a registered
 * level interrupt, with byte-writable word access.
 */
`timescale 1ns/1ns

module timer_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_sys_pkg::bus_req_t req_i,
  output mem_sys_pkg::data_t    rdata_o,
  output logic                  irq_o
);

  mem_sys_pkg::mtime_t mtime_q;
  mem_sys_pkg::mtime_t mtime_d;
  mem_sys_pkg::mtime_t cmp_q;
  mem_sys_pkg::mtime_t cmp_d;
  logic [1:0]          word_idx;
  logic                wr_en;

  assign word_idx = req_i.addr[3:2];
  assign wr_en    = req_i.req & req_i.we;

  //////////////////////////////
  // next register values
  //////////////////////////////
  always_comb begin
    mtime_d = mtime_q + 64'd1;  // counts on every clock.
    cmp_d   = cmp_q;
    if (wr_en) begin
      case (word_idx)
        mem_sys_pkg::TmrMtimeLo: begin
          mtime_d[31:0] = mem_sys_pkg::apply_strb(mtime_d[31:0], req_i.wdata, req_i.be);
        end
        mem_sys_pkg::TmrMtimeHi: begin
          mtime_d[63:32] = mem_sys_pkg::apply_strb(mtime_d[63:32], req_i.wdata, req_i.be);
        end
        mem_sys_pkg::TmrCmpLo: begin
          cmp_d[31:0] = mem_sys_pkg::apply_strb(cmp_q[31:0], req_i.wdata, req_i.be);
        end
        default: begin
          cmp_d[63:32] = mem_sys_pkg::apply_strb(cmp_q[63:32], req_i.wdata, req_i.be);
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q <= '0;
      cmp_q   <= mem_sys_pkg::TmrCmpReset;
      irq_o   <= 1'b0;
    end else begin
      mtime_q <= mtime_d;
      cmp_q   <= cmp_d;
      irq_o   <= (mtime_q >= cmp_q);  // level, one cycle behind the compare.
    end
  end

  //////////////////////////////
  // read data
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req) begin
      case (word_idx)
        mem_sys_pkg::TmrMtimeLo: rdata_o <= mtime_q[31:0];
        mem_sys_pkg::TmrMtimeHi: rdata_o <= mtime_q[63:32];
        mem_sys_pkg::TmrCmpLo:   rdata_o <= cmp_q[31:0];
        default:                 rdata_o <= cmp_q[63:32];
      endcase
    end
  end

endmodule

//--- tb.f
rtl/mem_sys_pkg.sv
rtl/bus_decode.sv
rtl/ram_1p.sv
rtl/timer_regs.sv
rtl/resp_mux.sv
rtl/mem_sys_top.sv
bench/tb_clk_gen.sv
bench/mem_sys_props.sv
bench/tb_mem_sys.sv
